// File: logic/soc_consts.svh
`ifndef SOC_CONSTS_SVH
`define SOC_CONSTS_SVH

// ------------------------------
// Serial bit timing
// ------------------------------

// Clock cycles per serial bit, start and stop bits included
`define SOC_CLKS_PER_BIT 8

// ------------------------------
// Echo buffer sizing
// ------------------------------

// 3 gives an 8-entry FIFO
`define SOC_FIFO_DEPTH_LOG2 3

// Serial payload width, one byte per frame
`define SOC_DATA_W 8

`endif

// File: logic/soc_pkg.sv
`default_nettype none

`include "soc_consts.svh"

package soc_pkg;

   // One serial payload byte
   typedef logic [`SOC_DATA_W-1:0] byte_t;

   // First reason the subsystem trapped
   typedef enum logic [1:0] {
      TRAP_NONE     = 2'd0,
      TRAP_FRAMING  = 2'd1,  // Stop bit sampled low
      TRAP_OVERFLOW = 2'd2   // Byte written into a full FIFO
   } trap_cause_t;

endpackage

`default_nettype wire

// File: logic/uart_pkg.sv
`default_nettype none

package uart_pkg;

   // ------------------------------
   // Receiver FSM
   // ------------------------------
   typedef enum logic [1:0] {
      RX_IDLE  = 2'd0,  // Waiting for a falling edge
      RX_START = 2'd1,  // Confirming start bit at its midpoint
      RX_DATA  = 2'd2,  // Shifting in data bits, LSB first
      RX_STOP  = 2'd3   // Checking the stop bit
   } rx_state_t;

   // ------------------------------
   // Transmitter FSM
   // ------------------------------
   typedef enum logic [1:0] {
      TX_IDLE  = 2'd0,  // Line held high
      TX_START = 2'd1,  // Driving the start bit
      TX_DATA  = 2'd2,  // Driving data bits, LSB first
      TX_STOP  = 2'd3   // Driving the stop bit
   } tx_state_t;

endpackage

`default_nettype wire

// File: logic/byte_fifo_if.sv
`timescale 1ns/1ps
`default_nettype none

interface byte_fifo_if;
   import soc_pkg::*;

   logic  wr_en;    // One-cycle write strobe
   byte_t wr_data;
   logic  rd_en;    // Pops the head entry
   byte_t rd_data;  // Head entry, valid while not empty
   logic  empty;

   // Receiver side, never looks at fullness
   modport producer (
      output wr_en,
      output wr_data
   );

   // Storage side
   modport buffer (
      input  wr_en,
      input  wr_data,
      input  rd_en,
      output rd_data,
      output empty
   );

   // Transmitter side
   modport consumer (
      output rd_en,
      input  rd_data,
      input  empty
   );

endinterface

`default_nettype wire

// File: logic/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

`include "soc_consts.svh"

module uart_rx (
   input  logic          clk_i,
   input  logic          rst_n_i,
   input  logic          rxd_i,
   byte_fifo_if.producer fifo,
   output logic          frame_err_o
);
   import soc_pkg::*;
   import uart_pkg::*;

   localparam int unsigned CLKS_PER_BIT = `SOC_CLKS_PER_BIT;
   localparam int unsigned HALF_BIT     = CLKS_PER_BIT / 2;
   localparam int unsigned CNT_W        = $clog2(CLKS_PER_BIT);
   localparam int unsigned DATA_W       = $bits(byte_t);
   localparam int unsigned IDX_W        = $clog2(DATA_W);

   logic             rxd_meta;
   logic             rxd_sync;
   logic             rxd_prev;   // For falling edge detection
   rx_state_t        state_q;
   logic [CNT_W-1:0] cnt_q;
   logic [IDX_W-1:0] bit_idx_q;
   byte_t            shift_q;
   logic             half_done;
   logic             bit_done;
   logic             stop_tick;

   // ------------------------------
   // Input synchronizer
   // ------------------------------
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         rxd_meta <= 1'b1;  // Idle line is high
         rxd_sync <= 1'b1;
         rxd_prev <= 1'b1;
      end else begin
         rxd_meta <= rxd_i;
         rxd_sync <= rxd_meta;
         rxd_prev <= rxd_sync;
      end
   end

   assign half_done = (cnt_q == CNT_W'(HALF_BIT - 1));
   assign bit_done  = (cnt_q == CNT_W'(CLKS_PER_BIT - 1));

   // ------------------------------
   // Frame FSM
   // ------------------------------
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q   <= RX_IDLE;
         cnt_q     <= '0;
         bit_idx_q <= '0;
      end else begin
         case (state_q)
            RX_IDLE: begin
               cnt_q <= '0;
               // Only a high-to-low edge starts a frame, so a low stop bit
               // does not retrigger
               if (rxd_prev && !rxd_sync) state_q <= RX_START;
            end
            RX_START: begin
               if (half_done) begin
                  cnt_q     <= '0;
                  bit_idx_q <= '0;
                  state_q   <= rxd_sync ? RX_IDLE : RX_DATA;  // High here is a glitch
               end else begin
                  cnt_q <= cnt_q + 1'b1;
               end
            end
            RX_DATA: begin
               if (bit_done) begin
                  cnt_q     <= '0;
                  bit_idx_q <= bit_idx_q + 1'b1;
                  if (bit_idx_q == IDX_W'(DATA_W - 1)) state_q <= RX_STOP;
               end else begin
                  cnt_q <= cnt_q + 1'b1;
               end
            end
            RX_STOP: begin
               if (bit_done) begin
                  cnt_q   <= '0;
                  state_q <= RX_IDLE;
               end else begin
                  cnt_q <= cnt_q + 1'b1;
               end
            end
            default: state_q <= RX_IDLE;
         endcase
      end
   end

   // LSB arrives first, so shift in from the top
   always_ff @(posedge clk_i) begin
      if (state_q == RX_DATA && bit_done) shift_q <= {rxd_sync, shift_q[DATA_W-1:1]};
   end

   // Stop bit midpoint decides between write and error
   assign stop_tick   = (state_q == RX_STOP) && bit_done;
   assign fifo.wr_en  = stop_tick && rxd_sync;
   assign fifo.wr_data = shift_q;
   assign frame_err_o = stop_tick && !rxd_sync;

endmodule

`default_nettype wire

// File: logic/byte_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "soc_consts.svh"

module byte_fifo (
   input  logic        clk_i,
   input  logic        rst_n_i,
   byte_fifo_if.buffer fifo,
   output logic        overflow_o
);
   import soc_pkg::*;

   localparam int unsigned PTR_W = `SOC_FIFO_DEPTH_LOG2;
   localparam int unsigned DEPTH = 1 << PTR_W;

   byte_t            mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr_q;
   logic [PTR_W-1:0] rd_ptr_q;
   logic [PTR_W:0]   count_q;    // 0 to DEPTH inclusive
   logic             full;
   logic             do_wr;
   logic             do_rd;

   assign full       = count_q[PTR_W];  // Top bit set only at DEPTH
   assign fifo.empty = (count_q == '0);
   assign do_wr      = fifo.wr_en && !full;
   assign do_rd      = fifo.rd_en && !fifo.empty;
   assign overflow_o = fifo.wr_en && full;  // Byte is dropped

   // First-word fall-through
   assign fifo.rd_data = mem[rd_ptr_q];

   always_ff @(posedge clk_i) begin
      if (do_wr) mem[wr_ptr_q] <= fifo.wr_data;
   end

   // ------------------------------
   // Pointers and occupancy
   // ------------------------------
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (do_wr) wr_ptr_q <= wr_ptr_q + 1'b1;  // Wraps at DEPTH
         if (do_rd) rd_ptr_q <= rd_ptr_q + 1'b1;
         case ({do_wr, do_rd})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;        // Both or neither
         endcase
      end
   end

endmodule

`default_nettype wire

// File: logic/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

`include "soc_consts.svh"

module uart_tx (
   input  logic          clk_i,
   input  logic          rst_n_i,
   input  logic          cts_i,
   byte_fifo_if.consumer fifo,
   output logic          txd_o
);
   import soc_pkg::*;
   import uart_pkg::*;

   localparam int unsigned CLKS_PER_BIT = `SOC_CLKS_PER_BIT;
   localparam int unsigned CNT_W        = $clog2(CLKS_PER_BIT);
   localparam int unsigned DATA_W       = $bits(byte_t);
   localparam int unsigned IDX_W        = $clog2(DATA_W);

   tx_state_t        state_q;
   logic [CNT_W-1:0] cnt_q;
   logic [IDX_W-1:0] bit_idx_q;
   byte_t            shift_q;
   logic             bit_done;

   assign bit_done = (cnt_q == CNT_W'(CLKS_PER_BIT - 1));

   // Pop only between frames, so cts_i low never cuts a frame short
   assign fifo.rd_en = (state_q == TX_IDLE) && !fifo.empty && cts_i;

   // ------------------------------
   // Frame FSM
   // ------------------------------
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q   <= TX_IDLE;
         cnt_q     <= '0;
         bit_idx_q <= '0;
         txd_o     <= 1'b1;
      end else begin
         if (state_q != TX_IDLE) cnt_q <= bit_done ? '0 : cnt_q + 1'b1;
         case (state_q)
            TX_IDLE: begin
               cnt_q <= '0;
               if (fifo.rd_en) begin
                  bit_idx_q <= '0;
                  txd_o     <= 1'b0;  // Start bit from the next cycle
                  state_q   <= TX_START;
               end
            end
            TX_START: begin
               if (bit_done) begin
                  txd_o   <= shift_q[0];
                  state_q <= TX_DATA;
               end
            end
            TX_DATA: begin
               if (bit_done) begin
                  bit_idx_q <= bit_idx_q + 1'b1;
                  if (bit_idx_q == IDX_W'(DATA_W - 1)) begin
                     txd_o   <= 1'b1;  // Stop bit
                     state_q <= TX_STOP;
                  end else begin
                     txd_o <= shift_q[0];
                  end
               end
            end
            TX_STOP: if (bit_done) state_q <= TX_IDLE;
            default: state_q <= TX_IDLE;
         endcase
      end
   end

   // Capture on pop, then shift out LSB first
   always_ff @(posedge clk_i) begin
      if (fifo.rd_en) begin
         shift_q <= fifo.rd_data;
      end else if (bit_done && (state_q == TX_START || state_q == TX_DATA)) begin
         shift_q <= shift_q >> 1;
      end
   end

endmodule

`default_nettype wire

// File: logic/uart_echo_fpga_wrapper.sv
`timescale 1ns/1ps
`default_nettype none

module uart_echo_fpga_wrapper (
   // User clock and board reset
   input  logic clk_i,
   input  logic rst_n_i,

   // UART pins
   input  logic rxd_i,
   input  logic cts_i,
   output logic txd_o,

   output logic trap_o
);
   import soc_pkg::*;

   logic        rst_meta_q;
   logic        rst_n;       // Inner reset, released synchronously
   logic        frame_err;
   logic        overflow;
   trap_cause_t trap_cause_q;

   byte_fifo_if fifo_if ();

   // ------------------------------
   // Reset synchronizer
   // ------------------------------
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         rst_meta_q <= 1'b0;
         rst_n      <= 1'b0;
      end else begin
         rst_meta_q <= 1'b1;
         rst_n      <= rst_meta_q;
      end
   end

   // ------------------------------
   // Sticky trap
   // ------------------------------
   always_ff @(posedge clk_i or negedge rst_n) begin
      if (!rst_n) begin
         trap_cause_q <= TRAP_NONE;
      end else if (trap_cause_q == TRAP_NONE) begin
         // Framing wins if both hit in one cycle
         if (frame_err)     trap_cause_q <= TRAP_FRAMING;
         else if (overflow) trap_cause_q <= TRAP_OVERFLOW;
      end
   end

   assign trap_o = (trap_cause_q != TRAP_NONE);

   // Receiver feeds the FIFO, transmitter drains it
   uart_rx uart_rx_i (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n),
      .rxd_i      (rxd_i),
      .fifo       (fifo_if.producer),
      .frame_err_o(frame_err)
   );

   byte_fifo byte_fifo_i (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n),
      .fifo      (fifo_if.buffer),
      .overflow_o(overflow)
   );

   uart_tx uart_tx_i (
      .clk_i  (clk_i),
      .rst_n_i(rst_n),
      .cts_i  (cts_i),
      .fifo   (fifo_if.consumer),
      .txd_o  (txd_o)
   );

endmodule

`default_nettype wire

// File: verification/tb_uart_echo.sv
`timescale 1ns/1ps
`default_nettype none

`include "soc_consts.svh"

module tb_uart_echo;

   localparam int CLKS_PER_BIT  = `SOC_CLKS_PER_BIT;
   localparam int DATA_W        = `SOC_DATA_W;
   localparam int FIFO_DEPTH    = 1 << `SOC_FIFO_DEPTH_LOG2;
   localparam int FRAME_CLKS    = 10 * CLKS_PER_BIT;
   localparam int IDLE_CLKS     = 20 * CLKS_PER_BIT;  // Quiet time after the last echo
   localparam int BURST_LEN     = 20;
   localparam int CLK_PERIOD_NS = 8;
   localparam int TOTAL_BYTES   = 1 + BURST_LEN + FIFO_DEPTH + (FIFO_DEPTH + 1) + 2;
   localparam int WATCHDOG_NS   = TOTAL_BYTES * 10 * CLKS_PER_BIT * CLK_PERIOD_NS * 3;

   logic clk_i;
   logic rst_n_i;
   logic rxd_i;
   logic cts_i;
   logic txd_o;
   logic trap_o;

   logic [DATA_W-1:0] rx_q[$];   // Bytes decoded from txd_o
   logic [DATA_W-1:0] exp_q[$];
   int                start_count;
   int                errors;

   uart_echo_fpga_wrapper uart_echo_fpga_wrapper_i (
      .clk_i  (clk_i),
      .rst_n_i(rst_n_i),
      .rxd_i  (rxd_i),
      .cts_i  (cts_i),
      .txd_o  (txd_o),
      .trap_o (trap_o)
   );

   always #4 clk_i = ~clk_i;

   // ------------------------------
   // Serial monitor on txd_o
   // ------------------------------
   always begin : txd_monitor
      logic [DATA_W-1:0] data;
      @(negedge txd_o);
      start_count++;
      repeat (CLKS_PER_BIT / 2) @(negedge clk_i);  // Middle of the start bit
      if (txd_o !== 1'b0) begin
         errors++;
         $display("Start bit on txd_o was not low at its middle");
      end else begin
         for (int i = 0; i < DATA_W; i++) begin
            repeat (CLKS_PER_BIT) @(negedge clk_i);
            data[i] = txd_o;  // LSB first
         end
         repeat (CLKS_PER_BIT) @(negedge clk_i);
         if (txd_o !== 1'b1) begin
            errors++;
            $display("[FAIL] txd_o stop bit: expected 0x1, got 0x%h", txd_o);
         end
         rx_q.push_back(data);
      end
   end

   initial begin : watchdog
      #(WATCHDOG_NS);
      $display("Watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
      $display("SOME TESTS FAILED");
      $finish;
   end

   // ------------------------------
   // Drivers and checkers
   // ------------------------------
   task automatic apply_reset();
      @(posedge clk_i);
      rst_n_i <= 1'b0;
      rxd_i   <= 1'b1;
      cts_i   <= 1'b1;
      repeat (3) @(posedge clk_i);
      rst_n_i <= 1'b1;
      repeat (4) @(posedge clk_i);  // Inner reset lags by two edges
      rx_q.delete();
      exp_q.delete();
      start_count = 0;
   endtask

   // Start bit, data LSB first, then the given stop bit
   task automatic send_frame(input logic [DATA_W-1:0] data, input logic stop_bit);
      logic [DATA_W+1:0] bits;
      bits = {stop_bit, data, 1'b0};
      for (int i = 0; i < DATA_W + 2; i++) begin
         @(posedge clk_i);
         rxd_i <= bits[i];
         repeat (CLKS_PER_BIT - 1) @(posedge clk_i);
      end
   endtask

   task automatic send_byte(input logic [DATA_W-1:0] data);
      send_frame(data, 1'b1);
      exp_q.push_back(data);
   endtask

   task automatic check_level(input string name, input logic actual, input logic expected);
      if (actual !== expected) begin
         errors++;
         $display("[FAIL] %s: expected 0x%h, got 0x%h", name, expected, actual);
      end
   endtask

   // Waits for the expected echoes, then stays a while to catch extra frames
   task automatic check_echo(input string test);
      int n;
      int waited;
      n = exp_q.size();
      waited = 0;
      while (rx_q.size() < n && waited < (n + 2) * FRAME_CLKS) begin
         @(posedge clk_i);
         waited++;
      end
      repeat (IDLE_CLKS) @(posedge clk_i);
      if (rx_q.size() < n) begin
         errors++;
         $display("%s: only %0d of %0d bytes were echoed", test, rx_q.size(), n);
      end else if (rx_q.size() > n) begin
         errors++;
         $display("%s: %0d bytes were echoed, %0d expected", test, rx_q.size(), n);
      end
      for (int i = 0; i < n && i < rx_q.size(); i++) begin
         if (rx_q[i] !== exp_q[i]) begin
            errors++;
            $display("[FAIL] txd_o byte %0d in %s: expected 0x%h, got 0x%h",
                     i, test, exp_q[i], rx_q[i]);
         end
      end
   endtask

   // ------------------------------
   // Tests
   // ------------------------------
   task automatic test_reset_state();
      apply_reset();
      check_level("txd_o", txd_o, 1'b1);
      check_level("trap_o", trap_o, 1'b0);
      repeat (20 * CLKS_PER_BIT) @(posedge clk_i);
      check_level("txd_o", txd_o, 1'b1);
      if (start_count != 0) begin
         errors++;
         $display("Idle line: txd_o started a frame with no input");
      end
   endtask

   task automatic test_single_echo();
      apply_reset();
      send_byte(8'ha5);
      check_echo("single echo");
      check_level("trap_o", trap_o, 1'b0);
   endtask

   task automatic test_random_burst();
      apply_reset();
      for (int i = 0; i < BURST_LEN; i++) send_byte(DATA_W'($urandom() & 32'hff));
      check_echo("random burst");
      check_level("trap_o", trap_o, 1'b0);
   endtask

   task automatic test_flow_control();
      apply_reset();
      @(posedge clk_i);
      cts_i <= 1'b0;
      for (int i = 0; i < FIFO_DEPTH; i++) send_byte(DATA_W'(8'hc0 + i));
      repeat (2 * CLKS_PER_BIT) @(posedge clk_i);
      if (start_count != 0) begin
         errors++;
         $display("Flow control: txd_o started %0d frames while cts_i was low", start_count);
      end
      @(posedge clk_i);
      cts_i <= 1'b1;
      check_echo("flow control");
      check_level("trap_o", trap_o, 1'b0);
   endtask

   task automatic test_overflow();
      apply_reset();
      @(posedge clk_i);
      cts_i <= 1'b0;
      for (int i = 0; i <= FIFO_DEPTH; i++) send_frame(DATA_W'(8'h10 + i), 1'b1);
      for (int i = 0; i < FIFO_DEPTH; i++) exp_q.push_back(DATA_W'(8'h10 + i));  // Last one lost
      repeat (2) @(posedge clk_i);
      check_level("trap_o", trap_o, 1'b1);
      cts_i <= 1'b1;
      check_echo("overflow");
   endtask

   task automatic test_framing_error();
      apply_reset();
      send_frame(8'h3c, 1'b0);  // Stop bit held low
      @(posedge clk_i);
      rxd_i <= 1'b1;
      repeat (2 * CLKS_PER_BIT) @(posedge clk_i);
      check_level("trap_o", trap_o, 1'b1);
      send_byte(8'h5a);
      check_echo("framing error");
      check_level("trap_o", trap_o, 1'b1);
      apply_reset();
      check_level("trap_o", trap_o, 1'b0);  // Only reset clears the trap
   endtask

   initial begin
      clk_i       = 1'b0;
      rst_n_i     = 1'b0;
      rxd_i       = 1'b1;
      cts_i       = 1'b1;
      errors      = 0;
      start_count = 0;
      void'($urandom(32'hb299));
      test_reset_state();
      test_single_echo();
      test_random_burst();
      test_flow_control();
      test_overflow();
      test_framing_error();
      $display("Run finished with %0d errors", errors);
      if (errors == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: compile.f
+incdir+logic
logic/soc_pkg.sv
logic/uart_pkg.sv
logic/byte_fifo_if.sv
logic/uart_rx.sv
logic/byte_fifo.sv
logic/uart_tx.sv
logic/uart_echo_fpga_wrapper.sv
verification/tb_uart_echo.sv

// File: Makefile
TOP := tb_uart_echo
BIN := obj_dir/V$(TOP)
LOG := sim.log

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): compile.f logic/*.sv logic/*.svh verification/*.sv
	verilator --binary --timing --top-module $(TOP) -Mdir obj_dir -f compile.f

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then \
		echo "Simulation reported failures, see $(LOG)"; \
		exit 1; \
	fi
	@grep -q "ALL TESTS PASSED" $(LOG) || { echo "No pass line in $(LOG)"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)
